/* rtl/boot_config.svh */
`ifndef BOOT_CONFIG_SVH
`define BOOT_CONFIG_SVH

////////////////////////////////////////////////////////////
// SPI NOR command codes
////////////////////////////////////////////////////////////

// Software reset is a two-byte sequence, enable then reset
`define FLASH_CMD_RESET_EN 8'h66
`define FLASH_CMD_RESET 8'h99
// Plain read, one byte per 8 SCK periods on IO1
`define FLASH_CMD_READ 8'h03

////////////////////////////////////////////////////////////
// Program image
////////////////////////////////////////////////////////////

// Flash byte address of the first image byte
`define IMAGE_BASE 24'h100000
// Image length in 16-bit words, also the depth of the word store
`define IMAGE_WORDS 16
// Word store address width, must cover IMAGE_WORDS
`define STORE_AW 4

////////////////////////////////////////////////////////////
// Timing
////////////////////////////////////////////////////////////

// CLK ticks per SCK half period
`define FLASH_HALF_PERIOD 8
// Settle time after the flash software reset
`define RESET_WAIT_TICKS 400
// CLK ticks per UART bit
`define BAUD_DIV 16

`endif

/* rtl/boot_pkg.sv */
package boot_pkg;

  // Kind of request handed to the SPI port
  // SEND_CMD    one byte, then deselect
  // OPEN_READ   command plus 24-bit address, stays selected
  // READ_BYTE   8 bits in on IO1, stays selected
  // CLOSE       deselect only
  typedef enum logic [1:0] {
    SEND_CMD,
    OPEN_READ,
    READ_BYTE,
    CLOSE
  } spi_op_e;

  // One flash request, held stable while the port works on it
  typedef struct packed {
    spi_op_e     op;
    logic [7:0]  cmd;
    logic [23:0] addr;
  } flash_req_t;

  // Flash pins driven by the controller
  typedef struct packed {
    logic sck;
    logic ssb;
    logic io0;
  } flash_pins_t;

  // Image word, built from a big-endian byte pair
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
  } flash_word_u;

endpackage

/* rtl/spi_flash_port.sv */
`include "boot_config.svh"

module spi_flash_port import boot_pkg::*; (
  input  logic        CLK,
  input  logic        arst_n,
  input  logic        flash_start,
  input  flash_req_t  flash_req,
  input  logic        io1,
  output logic        flash_done,
  output logic [7:0]  rx_byte,
  output flash_pins_t flash_pins
);

  localparam int DIV_W = $clog2(`FLASH_HALF_PERIOD);

  // Port sequencer
  localparam logic [1:0] PS_IDLE  = 2'd0;
  localparam logic [1:0] PS_SHIFT = 2'd1;
  localparam logic [1:0] PS_DESEL = 2'd2;

  logic [1:0]       state;
  logic [DIV_W-1:0] div_cnt;
  logic             sck_q;
  logic             ssb_q;
  logic [31:0]      out_sr;
  logic [7:0]       in_sr;
  logic [4:0]       bit_cnt;
  logic             half_tick;
  logic [31:0]      load_word;

  // SCK toggles at the end of every half period while shifting
  assign half_tick = (state == PS_SHIFT) && (div_cnt == DIV_W'(`FLASH_HALF_PERIOD - 1));

  // Outgoing bits, MSB first; reads shift out zeros so IO0 stays low
  always_comb begin
    case (flash_req.op)
      SEND_CMD:  load_word = {flash_req.cmd, 24'h000000};
      OPEN_READ: load_word = {flash_req.cmd, flash_req.addr};
      default:   load_word = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Framing, SCK divider and output shift
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state      <= PS_IDLE;
      div_cnt    <= '0;
      sck_q      <= 1'b0;
      ssb_q      <= 1'b1;
      out_sr     <= '0;
      bit_cnt    <= '0;
      flash_done <= 1'b0;
    end else begin
      flash_done <= 1'b0;
      case (state)
        PS_IDLE: begin
          if (flash_start) begin
            div_cnt <= '0;
            out_sr  <= load_word;
            bit_cnt <= (flash_req.op == OPEN_READ) ? 5'd31 : 5'd7;
            if (flash_req.op == CLOSE) begin
              // Deselect only, done next cycle
              ssb_q      <= 1'b1;
              flash_done <= 1'b1;
            end else begin
              ssb_q <= 1'b0;
              state <= PS_SHIFT;
            end
          end
        end
        PS_SHIFT: begin
          if (half_tick) begin
            div_cnt <= '0;
            sck_q   <= ~sck_q;
            // Falling edge moves IO0 to the next bit
            if (sck_q) begin
              out_sr  <= {out_sr[30:0], 1'b0};
              bit_cnt <= bit_cnt - 5'd1;
              if (bit_cnt == 5'd0) begin
                if (flash_req.op == SEND_CMD) begin
                  state <= PS_DESEL;
                end else begin
                  state      <= PS_IDLE;
                  flash_done <= 1'b1;
                end
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        PS_DESEL: begin
          // SCK is already low here
          ssb_q      <= 1'b1;
          flash_done <= 1'b1;
          state      <= PS_IDLE;
        end
        default: state <= PS_IDLE;
      endcase
    end
  end

  // IO1 is captured as SCK rises
  always_ff @(posedge CLK) begin
    if (half_tick && !sck_q) begin
      in_sr <= {in_sr[6:0], io1};
    end
  end

  assign rx_byte    = in_sr;
  assign flash_pins = '{sck: sck_q, ssb: ssb_q, io0: out_sr[31]};

endmodule

/* rtl/word_store.sv */
`include "boot_config.svh"

module word_store (
  input  logic                 CLK,
  input  logic                 store_we,
  input  logic [`STORE_AW-1:0] store_addr,
  input  logic [15:0]          store_wdata,
  output logic [15:0]          store_rdata
);

  // Loaded program image, one word per entry
  logic [15:0] mem [`IMAGE_WORDS];

  // Write port
  always_ff @(posedge CLK) begin
    if (store_we) begin
      mem[store_addr] <= store_wdata;
    end
  end

  // Registered read
  // data follows the address by one cycle
  always_ff @(posedge CLK) begin
    store_rdata <= mem[store_addr];
  end

endmodule

/* rtl/uart_tx.sv */
`include "boot_config.svh"

module uart_tx (
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       tx_send,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx
);

  localparam int BAUD_W = $clog2(`BAUD_DIV);

  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_idx;
  logic [8:0]        frame_sr;
  logic              bit_end;

  // Last tick of the current bit
  assign bit_end = (baud_cnt == BAUD_W'(`BAUD_DIV - 1));

  ////////////////////////////////////////////////////////////
  // 8N1 frame, start bit then data LSB first then stop bit
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tx_busy  <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (!tx_busy) begin
      if (tx_send) begin
        // Start bit goes out right away
        tx_busy  <= 1'b1;
        tx       <= 1'b0;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
    end else if (bit_end) begin
      baud_cnt <= '0;
      if (bit_idx == 4'd9) begin
        // Stop bit complete, line stays high
        tx_busy <= 1'b0;
      end else begin
        tx      <= frame_sr[0];
        bit_idx <= bit_idx + 4'd1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Data bits then stop bit
  // ones fill in from the top
  always_ff @(posedge CLK) begin
    if (!tx_busy && tx_send) begin
      frame_sr <= {1'b1, tx_byte};
    end else if (tx_busy && bit_end) begin
      frame_sr <= {1'b1, frame_sr[8:1]};
    end
  end

endmodule

/* rtl/boot_ctrl.sv */
`include "boot_config.svh"

module boot_ctrl import boot_pkg::*; (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic                 flash_done,
  input  logic [7:0]           rx_byte,
  input  logic [15:0]          store_rdata,
  input  logic                 tx_busy,
  output logic                 flash_start,
  output flash_req_t           flash_req,
  output logic                 store_we,
  output logic [`STORE_AW-1:0] store_addr,
  output logic [15:0]          store_wdata,
  output logic                 tx_send,
  output logic [7:0]           tx_byte,
  output logic                 boot_done
);

  localparam int AW     = `STORE_AW;
  localparam int WAIT_W = $clog2(`RESET_WAIT_TICKS);

  // Boot sequence
  localparam logic [3:0] ST_RST_EN  = 4'd0;
  localparam logic [3:0] ST_RST     = 4'd1;
  localparam logic [3:0] ST_WAIT    = 4'd2;
  localparam logic [3:0] ST_OPEN    = 4'd3;
  localparam logic [3:0] ST_READ_HI = 4'd4;
  localparam logic [3:0] ST_READ_LO = 4'd5;
  localparam logic [3:0] ST_WRITE   = 4'd6;
  localparam logic [3:0] ST_CLOSE   = 4'd7;
  localparam logic [3:0] ST_FETCH   = 4'd8;
  localparam logic [3:0] ST_LOAD    = 4'd9;
  localparam logic [3:0] ST_SEND_HI = 4'd10;
  localparam logic [3:0] ST_SEND_LO = 4'd11;
  localparam logic [3:0] ST_DRAIN   = 4'd12;
  localparam logic [3:0] ST_DONE    = 4'd13;

  logic [3:0]        state;
  logic              flash_wait;
  logic              flash_phase;
  logic [AW-1:0]     word_cnt;
  logic [WAIT_W-1:0] wait_cnt;
  flash_word_u       word_q;
  logic              last_word;

  assign last_word = (word_cnt == AW'(`IMAGE_WORDS - 1));

  ////////////////////////////////////////////////////////////
  // Flash request decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    flash_req   = '{op: CLOSE, cmd: 8'h00, addr: 24'h000000};
    flash_phase = 1'b1;
    case (state)
      ST_RST_EN: begin
        flash_req.op  = SEND_CMD;
        flash_req.cmd = `FLASH_CMD_RESET_EN;
      end
      ST_RST: begin
        flash_req.op  = SEND_CMD;
        flash_req.cmd = `FLASH_CMD_RESET;
      end
      ST_OPEN: begin
        flash_req.op   = OPEN_READ;
        flash_req.cmd  = `FLASH_CMD_READ;
        flash_req.addr = `IMAGE_BASE;
      end
      ST_READ_HI, ST_READ_LO: flash_req.op = READ_BYTE;
      ST_CLOSE:               flash_req.op = CLOSE;
      default:                flash_phase = 1'b0;
    endcase
  end

  // One start per flash state, then wait for done
  assign flash_start = flash_phase && !flash_wait;

  // Store access, same counter for load and dump
  assign store_we    = (state == ST_WRITE);
  assign store_addr  = word_cnt;
  assign store_wdata = word_q.word;

  // High byte first, only while the transmitter is idle
  assign tx_send   = ((state == ST_SEND_HI) || (state == ST_SEND_LO)) && !tx_busy;
  assign tx_byte   = (state == ST_SEND_HI) ? word_q.bytes.hi : word_q.bytes.lo;
  assign boot_done = (state == ST_DONE);

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_RST_EN;
      flash_wait <= 1'b0;
      word_cnt   <= '0;
      wait_cnt   <= '0;
    end else begin
      if (flash_start) begin
        flash_wait <= 1'b1;
      end else if (flash_done) begin
        flash_wait <= 1'b0;
      end
      case (state)
        ST_RST_EN: if (flash_done) state <= ST_RST;
        ST_RST: begin
          if (flash_done) begin
            wait_cnt <= '0;
            state    <= ST_WAIT;
          end
        end
        // Flash settles after software reset
        ST_WAIT: begin
          if (wait_cnt == WAIT_W'(`RESET_WAIT_TICKS - 1)) begin
            state <= ST_OPEN;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ST_OPEN: begin
          if (flash_done) begin
            word_cnt <= '0;
            state    <= ST_READ_HI;
          end
        end
        ST_READ_HI: if (flash_done) state <= ST_READ_LO;
        ST_READ_LO: if (flash_done) state <= ST_WRITE;
        ST_WRITE: begin
          if (last_word) begin
            word_cnt <= '0;
            state    <= ST_CLOSE;
          end else begin
            word_cnt <= word_cnt + 1'b1;
            state    <= ST_READ_HI;
          end
        end
        ST_CLOSE: if (flash_done) state <= ST_FETCH;
        // Address out, read data lands in ST_LOAD
        ST_FETCH:   state <= ST_LOAD;
        ST_LOAD:    state <= ST_SEND_HI;
        ST_SEND_HI: if (tx_send) state <= ST_SEND_LO;
        ST_SEND_LO: begin
          if (tx_send) begin
            if (last_word) begin
              state <= ST_DRAIN;
            end else begin
              word_cnt <= word_cnt + 1'b1;
              state    <= ST_FETCH;
            end
          end
        end
        // Last stop bit must finish before done
        ST_DRAIN: if (!tx_busy) state <= ST_DONE;
        ST_DONE:  state <= ST_DONE;
        default:  state <= ST_RST_EN;
      endcase
    end
  end

  // Word assembly, bytes in big-endian order
  always_ff @(posedge CLK) begin
    if (flash_done && (state == ST_READ_HI)) begin
      word_q.bytes.hi <= rx_byte;
    end
    if (flash_done && (state == ST_READ_LO)) begin
      word_q.bytes.lo <= rx_byte;
    end
    if (state == ST_LOAD) begin
      word_q.word <= store_rdata;
    end
  end

endmodule

/* rtl/flash_boot_top.sv */
`include "boot_config.svh"

module flash_boot_top import boot_pkg::*; (
  input  logic CLK,
  input  logic arst_n,
  input  logic flash_io1,
  output logic flash_sck,
  output logic flash_ssb,
  output logic flash_io0,
  output logic flash_io2,
  output logic flash_io3,
  output logic tx,
  output logic boot_done
);

  logic                 flash_start;
  flash_req_t           flash_req;
  logic                 flash_done;
  logic [7:0]           rx_byte;
  flash_pins_t          flash_pins;
  logic                 store_we;
  logic [`STORE_AW-1:0] store_addr;
  logic [15:0]          store_wdata;
  logic [15:0]          store_rdata;
  logic                 tx_send;
  logic [7:0]           tx_byte;
  logic                 tx_busy;

  // Sequencer
  boot_ctrl u_boot_ctrl (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .flash_done (flash_done),
    .rx_byte    (rx_byte),
    .store_rdata(store_rdata),
    .tx_busy    (tx_busy),
    .flash_start(flash_start),
    .flash_req  (flash_req),
    .store_we   (store_we),
    .store_addr (store_addr),
    .store_wdata(store_wdata),
    .tx_send    (tx_send),
    .tx_byte    (tx_byte),
    .boot_done  (boot_done)
  );

  // SPI mode 0 flash interface
  spi_flash_port u_spi_flash_port (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .flash_start(flash_start),
    .flash_req  (flash_req),
    .io1        (flash_io1),
    .flash_done (flash_done),
    .rx_byte    (rx_byte),
    .flash_pins (flash_pins)
  );

  // Image memory
  word_store u_word_store (
    .CLK        (CLK),
    .store_we   (store_we),
    .store_addr (store_addr),
    .store_wdata(store_wdata),
    .store_rdata(store_rdata)
  );

  // Readback dump
  uart_tx u_uart_tx (
    .CLK    (CLK),
    .arst_n (arst_n),
    .tx_send(tx_send),
    .tx_byte(tx_byte),
    .tx_busy(tx_busy),
    .tx     (tx)
  );

  assign flash_sck = flash_pins.sck;
  assign flash_ssb = flash_pins.ssb;
  assign flash_io0 = flash_pins.io0;

  // WP and HOLD inactive
  assign flash_io2 = 1'b1;
  assign flash_io3 = 1'b1;

endmodule

/* testbench/spi_flash_model.sv */
`include "boot_config.svh"

module spi_flash_model #(
  parameter int IMG_BYTES = 2 * `IMAGE_WORDS
) (
  input  logic                   sck,
  input  logic                   ssb,
  input  logic                   io0,
  input  logic [8*IMG_BYTES-1:0] image,
  output logic                   io1,
  output int                     frames,
  output int                     last_bits,
  output logic [31:0]            last_head,
  output longint                 last_gap
);

  timeunit 1ns;
  timeprecision 1ps;

  int          bit_cnt;
  int          offset;
  logic [7:0]  in_sr;
  logic [31:0] head;
  logic        selected;
  logic        read_mode;
  longint      desel_time;
  longint      sel_gap;

  initial begin
    io1        = 1'b0;
    frames     = 0;
    last_bits  = 0;
    last_head  = '0;
    last_gap   = 0;
    selected   = 1'b0;
    read_mode  = 1'b0;
    bit_cnt    = 0;
    head       = '0;
    in_sr      = '0;
    desel_time = 0;
  end

  ////////////////////////////////////////////////////////////
  // Frame start, time since the previous deselect
  ////////////////////////////////////////////////////////////

  always @(negedge ssb) begin
    selected  = 1'b1;
    read_mode = 1'b0;
    bit_cnt   = 0;
    head      = '0;
    sel_gap   = $time - desel_time;
  end

  // Mode 0, IO0 sampled on SCK rise
  always @(posedge sck) begin
    if (ssb === 1'b0) begin
      in_sr   = {in_sr[6:0], io0};
      bit_cnt = bit_cnt + 1;
      // First four bytes kept as the frame header
      if ((bit_cnt % 8 == 0) && (bit_cnt <= 32)) begin
        head = {head[23:0], in_sr};
        if ((bit_cnt == 8) && (in_sr == `FLASH_CMD_READ)) begin
          read_mode = 1'b1;
        end
      end
    end
  end

  // Read data moves after each SCK fall once the address is in
  always @(negedge sck) begin
    if ((ssb === 1'b0) && read_mode && (bit_cnt >= 32)) begin
      offset = int'(head[23:0]) - int'(`IMAGE_BASE) + (bit_cnt - 32) / 8;
      if ((offset >= 0) && (offset < IMG_BYTES)) begin
        io1 = image[8*offset + 7 - ((bit_cnt - 32) % 8)];
      end else begin
        io1 = 1'b0;
      end
    end
  end

  // Frame end, log is complete before the count moves
  always @(posedge ssb) begin
    if (selected) begin
      selected   = 1'b0;
      io1        = 1'b0;
      desel_time = $time;
      last_bits  = bit_cnt;
      last_head  = head;
      last_gap   = sel_gap;
      frames     = frames + 1;
    end
  end

endmodule

/* testbench/tb_flash_boot.sv */
`include "boot_config.svh"

module tb_flash_boot;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD    = 100;
  localparam int IW            = `IMAGE_WORDS;
  localparam int IMG_BYTES     = 2 * IW;
  localparam int READ_BYTES    = 4 + IMG_BYTES;
  localparam int BIT_NS        = CLK_PERIOD * `BAUD_DIV;
  localparam int RESET_WAIT_NS = CLK_PERIOD * `RESET_WAIT_TICKS;
  // Per boot limit counted from reset release
  localparam int WD_CYCLES = (`RESET_WAIT_TICKS
                              + (40 + 16 * IW) * 2 * `FLASH_HALF_PERIOD
                              + 20 * IW * `BAUD_DIV) * 2;

  logic                   CLK;
  logic                   arst_n;
  logic                   flash_io1;
  logic                   flash_sck;
  logic                   flash_ssb;
  logic                   flash_io0;
  logic                   flash_io2;
  logic                   flash_io3;
  logic                   tx;
  logic                   boot_done;
  logic [8*IMG_BYTES-1:0] image_bits;
  int                     frames;
  int                     last_bits;
  logic [31:0]            last_head;
  longint                 last_gap;
  int                     frame_base;
  int                     frame_idx;
  int                     rx_count;
  int                     wd_cycles;
  logic [7:0]             uart_byte;
  logic [7:0]             exp_cmd;

  flash_boot_top u_dut (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .flash_io1(flash_io1),
    .flash_sck(flash_sck),
    .flash_ssb(flash_ssb),
    .flash_io0(flash_io0),
    .flash_io2(flash_io2),
    .flash_io3(flash_io3),
    .tx       (tx),
    .boot_done(boot_done)
  );

  spi_flash_model u_flash (
    .sck      (flash_sck),
    .ssb      (flash_ssb),
    .io0      (flash_io0),
    .image    (image_bits),
    .io1      (flash_io1),
    .frames   (frames),
    .last_bits(last_bits),
    .last_head(last_head),
    .last_gap (last_gap)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic mismatch_error(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
    stop_run();
  endtask

  task automatic describe_failure(input string msg);
    $display("Failure: %s", msg);
    stop_run();
  endtask

  // Byte k of the image in flash order
  function automatic logic [7:0] image_byte(input int k);
    return image_bits[8*k +: 8];
  endfunction

  task automatic check_reset_outputs();
    assert (flash_ssb === 1'b1) else mismatch_error("flash_ssb", flash_ssb, 1);
    assert (flash_sck === 1'b0) else mismatch_error("flash_sck", flash_sck, 0);
    assert (tx === 1'b1) else mismatch_error("tx", tx, 1);
    assert (boot_done === 1'b0) else mismatch_error("boot_done", boot_done, 0);
  endtask

  // Reset held for 5 cycles
  // Frame and byte counters restart with the boot
  task automatic hold_reset();
    arst_n = 1'b0;
    #1;
    check_reset_outputs();
    repeat (5) @(posedge CLK);
    #1;
    frame_base = frames;
    rx_count   = 0;
    arst_n     = 1'b1;
    #1;
    check_reset_outputs();
  endtask

  ////////////////////////////////////////////////////////////
  // Pin rules
  ////////////////////////////////////////////////////////////

  assert property (@(posedge CLK) !arst_n |-> (flash_ssb && !flash_sck && tx && !boot_done))
    else describe_failure("outputs left their reset values while arst_n was low");
  assert property (@(posedge CLK) flash_io2 && flash_io3)
    else mismatch_error("flash_io2/io3", {flash_io2, flash_io3}, 2'b11);
  assert property (@(posedge CLK) disable iff (!arst_n) boot_done |=> boot_done)
    else describe_failure("boot_done fell without a reset");

  // Select edges only while SCK idles
  always @(flash_ssb) begin
    if (arst_n === 1'b1) begin
      assert (flash_sck === 1'b0) else mismatch_error("flash_sck at ssb edge", flash_sck, 0);
    end
  end

  // Quiet lines once the boot is over
  always @(flash_ssb or tx) begin
    if (boot_done === 1'b1) begin
      describe_failure("flash select or UART line moved after boot_done");
    end
  end

  // One check per completed flash frame
  always @(frames) begin
    #1;
    frame_idx = frames - frame_base;
    if ((frame_idx == 1) || (frame_idx == 2)) begin
      exp_cmd = (frame_idx == 1) ? `FLASH_CMD_RESET_EN : `FLASH_CMD_RESET;
      assert (last_bits == 8) else mismatch_error("reset frame bit count", last_bits, 8);
      assert (last_head[7:0] == exp_cmd)
        else mismatch_error("flash_io0 command", last_head[7:0], exp_cmd);
    end else if (frame_idx == 3) begin
      assert (last_gap >= RESET_WAIT_NS)
        else describe_failure("read frame opened before the reset wait was over");
      assert (last_head == {`FLASH_CMD_READ, `IMAGE_BASE})
        else mismatch_error("flash_io0 read header", last_head, {`FLASH_CMD_READ, `IMAGE_BASE});
      assert (last_bits == 8 * READ_BYTES)
        else mismatch_error("read frame bit count", last_bits, 8 * READ_BYTES);
    end else begin
      describe_failure("flash was selected more than three times in one boot");
    end
  end

  ////////////////////////////////////////////////////////////
  // UART decoder sampling tx at mid-bit
  ////////////////////////////////////////////////////////////

  always begin
    @(negedge tx);
    if (arst_n === 1'b1) begin
      #(BIT_NS / 2);
      assert (tx === 1'b0) else describe_failure("UART start bit was not low at mid-bit");
      for (int i = 0; i < 8; i++) begin
        #(BIT_NS);
        uart_byte[i] = tx;
      end
      #(BIT_NS);
      assert (tx === 1'b1) else mismatch_error("tx stop bit", tx, 1);
      assert (rx_count < IMG_BYTES) else describe_failure("more UART bytes than image bytes");
      assert (uart_byte == image_byte(rx_count))
        else mismatch_error("tx byte", uart_byte, image_byte(rx_count));
      rx_count = rx_count + 1;
    end
  end

  // Watchdog restarts with every reset
  always @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wd_cycles <= 0;
    end else begin
      wd_cycles <= wd_cycles + 1;
      if (wd_cycles > WD_CYCLES) begin
        describe_failure("watchdog expired before the boot finished");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    CLK        = 1'b0;
    arst_n     = 1'b1;
    frame_base = 0;
    rx_count   = 0;
    void'($urandom(32'h55cc9015));
    for (int k = 0; k < IMG_BYTES; k++) begin
      image_bits[8*k +: 8] = 8'($urandom);
    end
    // Reset edge lands before the first clock edge
    #1;
    hold_reset();
    // First boot cut off halfway through the dump
    wait (rx_count == IW);
    @(posedge CLK);
    #1;
    hold_reset();
    // Second boot runs to the end
    wait (boot_done === 1'b1);
    assert (rx_count == IMG_BYTES) else mismatch_error("tx byte count", rx_count, IMG_BYTES);
    assert (frames - frame_base == 3)
      else mismatch_error("flash frame count", frames - frame_base, 3);
    assert (tx === 1'b1) else mismatch_error("tx at boot_done", tx, 1);
    repeat (20 * `BAUD_DIV) @(posedge CLK);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* flash_boot_top.f */
+incdir+rtl
rtl/boot_pkg.sv
rtl/spi_flash_port.sv
rtl/word_store.sv
rtl/uart_tx.sv
rtl/boot_ctrl.sv
rtl/flash_boot_top.sv
testbench/spi_flash_model.sv
testbench/tb_flash_boot.sv
